// File: falafel.f
+incdir+.
falafel_pkg.sv
falafel_lsu_if.sv
falafel_lsu.sv
falafel_ctrl.sv
falafel_top.sv
falafel_asserts.sv
falafel_tb.sv

// File: falafel_tb.sv
`include "falafel_params.svh"

module falafel_tb;
  import falafel_pkg::*;

  localparam ptr_t HEAD    = 32'h0000_0100;
  localparam int   TIMEOUT = 2000;  // cycles per wait

  logic  clk_i;
  logic  rst_ni;
  ptr_t  free_list_ptr_i;
  logic  alloc_empty_i;
  logic  alloc_read_o;
  word_t alloc_size_i;
  logic  free_empty_i;
  logic  free_read_o;
  ptr_t  free_ptr_i;
  logic  resp_full_i;
  logic  resp_write_o;
  ptr_t  resp_ptr_o;
  logic  mem_req_val_o;
  logic  mem_req_rdy_i;
  logic  mem_req_is_write_o;
  ptr_t  mem_req_addr_o;
  word_t mem_req_data_o;
  logic  mem_rsp_val_i;
  logic  mem_rsp_rdy_o;
  word_t mem_rsp_data_i;

  word_t mem [ptr_t];  // indexed by word address
  int    write_cnt;
  logic  rsp_queued;
  logic  rsp_fire;
  word_t rsp_word;
  int    order_cnt;
  int    alloc_ord;
  int    free_ord;
  int    resp_ord;

  falafel_top i_falafel_top (.*);

  bind falafel_top falafel_top_asserts i_asserts (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic word_t mem_peek(input ptr_t addr);
    if (mem.exists(addr >> 2)) return mem[addr >> 2];
    return addr ^ 32'h5a5a_c3c3;  // never written
  endfunction

  function automatic void poke(input ptr_t addr, input word_t data);
    mem[addr >> 2] = data;
  endfunction

  function automatic word_t round_up(input word_t s);
    return ((s + `FALAFEL_ALIGN - 1) / `FALAFEL_ALIGN) * `FALAFEL_ALIGN;
  endfunction

  // memory model that answers one cycle after accepting a request
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      mem_req_rdy_i = 1'b0;
      mem_rsp_val_i = 1'b0;
      rsp_queued    = 1'b0;
      rsp_fire      = 1'b0;
    end else begin
      if (rsp_fire) begin
        mem_rsp_val_i = 1'b0;
        rsp_fire      = 1'b0;
      end
      if (rsp_queued) begin
        mem_rsp_val_i  = 1'b1;
        mem_rsp_data_i = rsp_word;
        rsp_queued     = 1'b0;
      end
      if (mem_rsp_val_i && mem_rsp_rdy_o) rsp_fire = 1'b1;
      mem_req_rdy_i = ($urandom_range(3) != 0);  // stall about one cycle in four
      if (mem_req_val_o && mem_req_rdy_i) begin
        if (mem_req_is_write_o) begin
          poke(mem_req_addr_o, mem_req_data_o);
          write_cnt++;
          rsp_word = '0;
        end else begin
          rsp_word = mem_peek(mem_req_addr_o);
        end
        rsp_queued = 1'b1;
      end
    end
  end

  task automatic expect_eq(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      $display("** FAIL **");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timed out waiting for %s", what);
    $display("** FAIL **");
    $fatal(1, "wait ran past its cycle limit");
  endtask

  task automatic push_alloc(input word_t size);
    int t;
    t = 0;
    @(negedge clk_i);
    alloc_size_i  = size;
    alloc_empty_i = 1'b0;
    #5;
    while (!alloc_read_o) begin
      if (t == TIMEOUT) timeout_fail("alloc_read_o");
      t++;
      @(negedge clk_i);
      #5;
    end
    order_cnt++;
    alloc_ord = order_cnt;
    @(negedge clk_i);
    alloc_empty_i = 1'b1;
  endtask

  task automatic push_free(input ptr_t p);
    int t;
    t = 0;
    @(negedge clk_i);
    free_ptr_i   = p;
    free_empty_i = 1'b0;
    #5;
    while (!free_read_o) begin
      if (t == TIMEOUT) timeout_fail("free_read_o");
      t++;
      @(negedge clk_i);
      #5;
    end
    order_cnt++;
    free_ord = order_cnt;
    @(negedge clk_i);
    free_empty_i = 1'b1;
  endtask

  task automatic collect(output ptr_t ptr);
    int t;
    t = 0;
    @(negedge clk_i);
    #5;
    while (!resp_write_o) begin
      if (t == TIMEOUT) timeout_fail("resp_write_o");
      t++;
      @(negedge clk_i);
      #5;
    end
    ptr = resp_ptr_o;
    order_cnt++;
    resp_ord = order_cnt;
  endtask

  task automatic wait_writes(input int n);
    int t;
    t = 0;
    while (write_cnt < n) begin
      if (t == TIMEOUT) timeout_fail("memory writes");
      t++;
      @(negedge clk_i);
      #5;
    end
  endtask

  task automatic alloc_one(input word_t size, output ptr_t ptr);
    fork
      push_alloc(size);
      collect(ptr);
    join
  endtask

  task automatic free_one(input ptr_t p);
    int target;
    target = write_cnt + 2;  // next field and link
    push_free(p);
    wait_writes(target);
  endtask

  task automatic clear_mem();
    mem.delete();
    write_cnt = 0;
  endtask

  task automatic test_split();
    word_t old_size;
    ptr_t  old_next;
    ptr_t  rem;
    ptr_t  got;
    clear_mem();
    poke(HEAD, 32'h1000);
    poke(32'h1000, 200);
    poke(32'h1004, 32'h2000);
    poke(32'h2000, 16);
    poke(32'h2004, `FALAFEL_NULL);
    alloc_one(0, got);
    expect_eq("zero size result", `FALAFEL_NULL, got);
    expect_eq("zero size writes", 0, write_cnt);
    old_size = mem_peek(32'h1000);
    old_next = mem_peek(32'h1004);
    rem = 32'h1000 + `FALAFEL_WORD_BYTES + round_up(20);
    alloc_one(20, got);
    expect_eq("split result", 32'h1004, got);
    expect_eq("split size word", 24, mem_peek(32'h1000));
    expect_eq("split new size", old_size - 28, mem_peek(rem));
    expect_eq("split new next", old_next, mem_peek(rem + 4));
    expect_eq("split head", rem, mem_peek(HEAD));
  endtask

  task automatic test_unlink();
    ptr_t got;
    ptr_t old_next;
    clear_mem();
    poke(HEAD, 32'h1000);
    poke(32'h1000, 8);
    poke(32'h1004, 32'h1100);
    poke(32'h1100, 40);
    poke(32'h1104, 32'h1200);
    poke(32'h1200, 24);
    poke(32'h1204, `FALAFEL_NULL);
    old_next = mem_peek(32'h1104);
    alloc_one(36, got);
    expect_eq("unlink mid result", 32'h1104, got);
    expect_eq("unlink mid link", old_next, mem_peek(32'h1004));
    expect_eq("unlink mid size", 40, mem_peek(32'h1100));
    old_next = mem_peek(32'h1204);
    alloc_one(12, got);  // walks past the 8-byte block
    expect_eq("walk result", 32'h1204, got);
    expect_eq("walk link", old_next, mem_peek(32'h1004));
    expect_eq("walk size", 24, mem_peek(32'h1200));
    old_next = mem_peek(32'h1004);
    alloc_one(5, got);
    expect_eq("unlink first result", 32'h1004, got);
    expect_eq("unlink first head", old_next, mem_peek(HEAD));
  endtask

  task automatic test_nomem();
    ptr_t got;
    clear_mem();
    poke(HEAD, 32'h1000);
    poke(32'h1000, 16);
    poke(32'h1004, 32'h1100);
    poke(32'h1100, 32);
    poke(32'h1104, `FALAFEL_NULL);
    alloc_one(100, got);
    expect_eq("nomem result", `FALAFEL_ERR_NOMEM, got);
    expect_eq("nomem writes", 0, write_cnt);
    expect_eq("nomem head", 32'h1000, mem_peek(HEAD));
    expect_eq("nomem next", 32'h1100, mem_peek(32'h1004));
  endtask

  task automatic test_free_order();
    ptr_t  got;
    word_t old_size;
    clear_mem();
    poke(HEAD, `FALAFEL_NULL);
    poke(32'h3000, 16);
    poke(32'h3100, 48);
    poke(32'h3200, 32);
    free_one(32'h3104);
    free_one(32'h3004);
    free_one(32'h3204);
    expect_eq("free head", 32'h3000, mem_peek(HEAD));
    expect_eq("free next 3000", 32'h3100, mem_peek(32'h3004));
    expect_eq("free next 3100", 32'h3200, mem_peek(32'h3104));
    expect_eq("free next 3200", `FALAFEL_NULL, mem_peek(32'h3204));
    old_size = mem_peek(32'h3100);
    alloc_one(24, got);  // 16-byte block is too small
    expect_eq("free then alloc result", 32'h3104, got);
    expect_eq("free then alloc size", 24, mem_peek(32'h3100));
    expect_eq("free then alloc rem", old_size - 28, mem_peek(32'h311c));
    expect_eq("free then alloc link", 32'h311c, mem_peek(32'h3004));
    expect_eq("free then alloc rem next", 32'h3200, mem_peek(32'h3120));
  endtask

  task automatic test_backpressure();
    ptr_t held;
    ptr_t got;
    clear_mem();
    poke(HEAD, 32'h4000);
    poke(32'h4000, 64);
    poke(32'h4004, `FALAFEL_NULL);
    poke(32'h5000, 16);
    order_cnt = 0;
    @(negedge clk_i);
    resp_full_i = 1'b1;
    fork
      push_alloc(8);
      push_free(32'h5004);
      begin
        wait_writes(4);  // size word, split block, link
        repeat (10) begin
          @(negedge clk_i);
          #5;
          expect_eq("held while full", 0, resp_write_o);
        end
        held = resp_ptr_o;
        @(negedge clk_i);
        resp_full_i = 1'b0;
        #5;
        expect_eq("write once not full", 1, resp_write_o);
        got = resp_ptr_o;
        order_cnt++;
        resp_ord = order_cnt;
      end
    join
    wait_writes(6);
    expect_eq("full result", 32'h4004, got);
    expect_eq("full result held", held, got);
    expect_eq("alloc read first", 1, alloc_ord);
    expect_eq("response before free", 2, resp_ord);
    expect_eq("free read last", 3, free_ord);
    expect_eq("free link", 32'h5000, mem_peek(32'h4010));
    expect_eq("free next", `FALAFEL_NULL, mem_peek(32'h5004));
  endtask

  initial begin
    void'($urandom(91277));
    rst_ni          = 1'b0;
    free_list_ptr_i = HEAD;
    alloc_empty_i   = 1'b1;
    alloc_size_i    = '0;
    free_empty_i    = 1'b1;
    free_ptr_i      = '0;
    resp_full_i     = 1'b0;
    mem_req_rdy_i   = 1'b0;
    mem_rsp_val_i   = 1'b0;
    mem_rsp_data_i  = '0;
    write_cnt       = 0;
    order_cnt       = 0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    test_split();
    test_unlink();
    test_nomem();
    test_free_order();
    test_backpressure();
    repeat (4) @(negedge clk_i);
    if (i_falafel_top.i_asserts.err_cnt != 0) begin
      $display("%0d assertion failures", i_falafel_top.i_asserts.err_cnt);
      $display("** FAIL **");
      $fatal(1, "assertions failed during the run");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

// File: falafel_asserts.sv
module falafel_top_asserts (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               alloc_read_o,
  input logic               free_read_o,
  input logic               resp_full_i,
  input logic               resp_write_o,
  input logic               mem_req_val_o,
  input logic               mem_req_rdy_i,
  input logic               mem_req_is_write_o,
  input falafel_pkg::ptr_t  mem_req_addr_o,
  input falafel_pkg::word_t mem_req_data_o,
  input logic               mem_rsp_rdy_o
);

  int unsigned err_cnt = 0;  // failed assertion count

  // a stalled request keeps address, data and direction
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_val_o && !mem_req_rdy_i |=> mem_req_val_o && $stable(mem_req_addr_o)
      && $stable(mem_req_data_o) && $stable(mem_req_is_write_o))
    else begin
      $error("memory request changed while stalled");
      err_cnt++;
    end

  no_write_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_full_i |-> !resp_write_o)
    else begin
      $error("response written while the response FIFO is full");
      err_cnt++;
    end

  one_fifo_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(alloc_read_o && free_read_o))
    else begin
      $error("alloc and free FIFOs read in the same cycle");
      err_cnt++;
    end

  // from the second reset cycle on, once the flops have been cleared
  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni && $past(!rst_ni) |-> !mem_req_val_o && !mem_rsp_rdy_o && !alloc_read_o
      && !free_read_o && !resp_write_o)
    else begin
      $error("strobe high during reset");
      err_cnt++;
    end

endmodule

// File: falafel_top.sv
module falafel_top (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  falafel_pkg::ptr_t  free_list_ptr_i,  // address of the head word

  input  logic               alloc_empty_i,
  output logic               alloc_read_o,
  input  falafel_pkg::word_t alloc_size_i,

  input  logic               free_empty_i,
  output logic               free_read_o,
  input  falafel_pkg::ptr_t  free_ptr_i,

  input  logic               resp_full_i,
  output logic               resp_write_o,
  output falafel_pkg::ptr_t  resp_ptr_o,

  output logic               mem_req_val_o,
  input  logic               mem_req_rdy_i,
  output logic               mem_req_is_write_o,
  output falafel_pkg::ptr_t  mem_req_addr_o,
  output falafel_pkg::word_t mem_req_data_o,

  input  logic               mem_rsp_val_i,
  output logic               mem_rsp_rdy_o,
  input  falafel_pkg::word_t mem_rsp_data_i
);

  falafel_lsu_if lsu_if ();

  falafel_ctrl i_falafel_ctrl (
    .clk_i,
    .rst_ni,
    .free_list_ptr_i,
    .alloc_empty_i,
    .alloc_read_o,
    .alloc_size_i,
    .free_empty_i,
    .free_read_o,
    .free_ptr_i,
    .resp_full_i,
    .resp_write_o,
    .resp_ptr_o,
    .lsu              (lsu_if)
  );

  // single outstanding memory transaction
  falafel_lsu i_falafel_lsu (
    .clk_i,
    .rst_ni,
    .lsu                (lsu_if),
    .mem_req_val_o,
    .mem_req_rdy_i,
    .mem_req_is_write_o,
    .mem_req_addr_o,
    .mem_req_data_o,
    .mem_rsp_val_i,
    .mem_rsp_rdy_o,
    .mem_rsp_data_i
  );

endmodule

// File: falafel_ctrl.sv
`include "falafel_params.svh"

module falafel_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  falafel_pkg::ptr_t  free_list_ptr_i,

  input  logic               alloc_empty_i,
  output logic               alloc_read_o,
  input  falafel_pkg::word_t alloc_size_i,

  input  logic               free_empty_i,
  output logic               free_read_o,
  input  falafel_pkg::ptr_t  free_ptr_i,

  input  logic               resp_full_i,
  output logic               resp_write_o,
  output falafel_pkg::ptr_t  resp_ptr_o,

  falafel_lsu_if.ctrl        lsu
);
  import falafel_pkg::*;

  localparam word_t WORD        = word_t'(`FALAFEL_WORD_BYTES);
  localparam word_t ALIGN_MASK  = word_t'(`FALAFEL_ALIGN - 1);
  localparam word_t SPLIT_LIMIT = word_t'(`FALAFEL_WORD_BYTES + `FALAFEL_MIN_SPLIT);

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_LOAD_HEAD,
    ST_WAIT_HEAD,
    ST_NEXT,         // decide on the pointer just read
    ST_LOAD_BLOCK,
    ST_WAIT_BLOCK,
    ST_BLOCK,        // fit check on the loaded block
    ST_STORE_SIZE,
    ST_WAIT_SIZE,
    ST_STORE_SPLIT,
    ST_WAIT_SPLIT,
    ST_STORE_INS,
    ST_WAIT_INS,
    ST_STORE_LINK,
    ST_WAIT_LINK,
    ST_RESP
  } ctrl_state_e;

  ctrl_state_e state_d, state_q;
  logic        is_free_d, is_free_q;

  word_t req_d, req_q;              // rounded alloc size
  ptr_t  blk_d, blk_q;              // header being freed
  ptr_t  cur_d, cur_q;              // header of the loaded block
  word_t size_d, size_q;            // its size word
  ptr_t  next_d, next_q;            // next header to visit
  ptr_t  link_addr_d, link_addr_q;  // word that points at next_q
  ptr_t  link_val_d, link_val_q;
  ptr_t  result_d, result_q;

  logic  fit;
  logic  split;
  ptr_t  split_addr;
  word_t split_size;

  assign fit        = (size_q >= req_q);
  assign split      = ((size_q - req_q) >= SPLIT_LIMIT);  // no underflow once fit holds
  assign split_addr = cur_q + WORD + req_q;
  assign split_size = size_q - req_q - WORD;

  assign resp_ptr_o = result_q;

  always_comb begin
    state_d     = state_q;
    is_free_d   = is_free_q;
    req_d       = req_q;
    blk_d       = blk_q;
    cur_d       = cur_q;
    size_d      = size_q;
    next_d      = next_q;
    link_addr_d = link_addr_q;
    link_val_d  = link_val_q;
    result_d    = result_q;

    lsu.req_val = 1'b0;
    lsu.op      = `FALAFEL_OP_LOAD_WORD;
    lsu.addr    = '0;
    lsu.wdata0  = '0;
    lsu.wdata1  = '0;
    lsu.rsp_rdy = 1'b0;

    alloc_read_o = 1'b0;
    free_read_o  = 1'b0;
    resp_write_o = 1'b0;

    unique case (state_q)
      ST_IDLE: begin
        if (!alloc_empty_i) begin
          alloc_read_o = 1'b1;
          is_free_d    = 1'b0;
          if (alloc_size_i == '0) begin
            result_d = `FALAFEL_NULL;
            state_d  = ST_RESP;
          end else begin
            req_d   = (alloc_size_i + ALIGN_MASK) & ~ALIGN_MASK;
            state_d = ST_LOAD_HEAD;
          end
        end else if (!free_empty_i) begin
          free_read_o = 1'b1;
          is_free_d   = 1'b1;
          blk_d       = free_ptr_i - WORD;
          state_d     = ST_LOAD_HEAD;
        end
      end

      ST_LOAD_HEAD: begin
        lsu.req_val = 1'b1;
        lsu.op      = `FALAFEL_OP_LOAD_WORD;
        lsu.addr    = free_list_ptr_i;
        link_addr_d = free_list_ptr_i;
        if (lsu.req_rdy) state_d = ST_WAIT_HEAD;
      end

      ST_WAIT_HEAD: begin
        lsu.rsp_rdy = 1'b1;
        if (lsu.rsp_val) begin
          next_d  = lsu.rdata0;
          state_d = ST_NEXT;
        end
      end

      ST_NEXT: begin
        if (is_free_q) begin
          if (next_q == `FALAFEL_NULL || next_q > blk_q) begin
            link_val_d = blk_q;  // insert B before next_q
            state_d    = ST_STORE_INS;
          end else begin
            state_d = ST_LOAD_BLOCK;
          end
        end else if (next_q == `FALAFEL_NULL) begin
          result_d = `FALAFEL_ERR_NOMEM;  // end of list, nothing written
          state_d  = ST_RESP;
        end else begin
          state_d = ST_LOAD_BLOCK;
        end
      end

      ST_LOAD_BLOCK: begin
        lsu.req_val = 1'b1;
        lsu.op      = `FALAFEL_OP_LOAD_BLOCK;
        lsu.addr    = next_q;
        if (lsu.req_rdy) begin
          cur_d   = next_q;
          state_d = ST_WAIT_BLOCK;
        end
      end

      ST_WAIT_BLOCK: begin
        lsu.rsp_rdy = 1'b1;
        if (lsu.rsp_val) begin
          size_d  = lsu.rdata0;
          next_d  = lsu.rdata1;
          state_d = ST_BLOCK;
        end
      end

      ST_BLOCK: begin
        if (!is_free_q && fit) begin
          result_d = cur_q + WORD;
          if (split) begin
            state_d = ST_STORE_SIZE;
          end else begin
            link_val_d = next_q;  // unlink the whole block
            state_d    = ST_STORE_LINK;
          end
        end else begin
          link_addr_d = cur_q + WORD;
          state_d     = ST_NEXT;
        end
      end

      ST_STORE_SIZE: begin
        lsu.req_val = 1'b1;
        lsu.op      = `FALAFEL_OP_STORE_WORD;
        lsu.addr    = cur_q;
        lsu.wdata0  = req_q;
        if (lsu.req_rdy) state_d = ST_WAIT_SIZE;
      end

      ST_WAIT_SIZE: begin
        lsu.rsp_rdy = 1'b1;
        if (lsu.rsp_val) state_d = ST_STORE_SPLIT;
      end

      ST_STORE_SPLIT: begin
        lsu.req_val = 1'b1;
        lsu.op      = `FALAFEL_OP_STORE_BLOCK;
        lsu.addr    = split_addr;
        lsu.wdata0  = split_size;
        lsu.wdata1  = next_q;
        link_val_d  = split_addr;
        if (lsu.req_rdy) state_d = ST_WAIT_SPLIT;
      end

      ST_WAIT_SPLIT: begin
        lsu.rsp_rdy = 1'b1;
        if (lsu.rsp_val) state_d = ST_STORE_LINK;
      end

      ST_STORE_INS: begin
        lsu.req_val = 1'b1;
        lsu.op      = `FALAFEL_OP_STORE_WORD;
        lsu.addr    = blk_q + WORD;
        lsu.wdata0  = next_q;
        if (lsu.req_rdy) state_d = ST_WAIT_INS;
      end

      ST_WAIT_INS: begin
        lsu.rsp_rdy = 1'b1;
        if (lsu.rsp_val) state_d = ST_STORE_LINK;
      end

      ST_STORE_LINK: begin
        lsu.req_val = 1'b1;
        lsu.op      = `FALAFEL_OP_STORE_WORD;
        lsu.addr    = link_addr_q;
        lsu.wdata0  = link_val_q;
        if (lsu.req_rdy) state_d = ST_WAIT_LINK;
      end

      ST_WAIT_LINK: begin
        lsu.rsp_rdy = 1'b1;
        if (lsu.rsp_val) state_d = is_free_q ? ST_IDLE : ST_RESP;  // free has no response
      end

      ST_RESP: begin
        if (!resp_full_i) begin
          resp_write_o = 1'b1;
          state_d      = ST_IDLE;
        end
      end

      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= ST_IDLE;
      is_free_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      is_free_q <= is_free_d;
    end
  end

  always_ff @(posedge clk_i) begin
    req_q       <= req_d;
    blk_q       <= blk_d;
    cur_q       <= cur_d;
    size_q      <= size_d;
    next_q      <= next_d;
    link_addr_q <= link_addr_d;
    link_val_q  <= link_val_d;
    result_q    <= result_d;
  end

endmodule

// File: falafel_lsu.sv
`include "falafel_params.svh"

module falafel_lsu (
  input  logic               clk_i,
  input  logic               rst_ni,

  falafel_lsu_if.lsu         lsu,

  output logic               mem_req_val_o,
  input  logic               mem_req_rdy_i,
  output logic               mem_req_is_write_o,
  output falafel_pkg::ptr_t  mem_req_addr_o,
  output falafel_pkg::word_t mem_req_data_o,

  input  logic               mem_rsp_val_i,
  output logic               mem_rsp_rdy_o,
  input  falafel_pkg::word_t mem_rsp_data_i
);
  import falafel_pkg::*;

  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_REQ,
    LSU_WAIT,
    LSU_RSP
  } lsu_state_e;

  lsu_state_e state_d, state_q;
  logic       word_sel_d, word_sel_q;  // 1 while on the word at addr+WORD

  lsu_op_t op_q;
  ptr_t    addr_q;
  word_t   wdata0_q;
  word_t   wdata1_q;
  word_t   rdata0_q;
  word_t   rdata1_q;

  logic is_store;
  logic is_block;
  logic req_fire;
  logic mem_rsp_fire;

  assign is_store = (op_q == `FALAFEL_OP_STORE_WORD) || (op_q == `FALAFEL_OP_STORE_BLOCK);
  assign is_block = (op_q == `FALAFEL_OP_LOAD_BLOCK) || (op_q == `FALAFEL_OP_STORE_BLOCK);

  assign req_fire     = lsu.req_val && lsu.req_rdy;
  assign mem_rsp_fire = mem_rsp_val_i && mem_rsp_rdy_o;

  assign lsu.req_rdy = (state_q == LSU_IDLE);
  assign lsu.rsp_val = (state_q == LSU_RSP);
  assign lsu.rdata0  = rdata0_q;
  assign lsu.rdata1  = rdata1_q;

  assign mem_req_val_o      = (state_q == LSU_REQ);
  assign mem_req_is_write_o = is_store;
  assign mem_req_addr_o     = word_sel_q ? addr_q + `FALAFEL_WORD_BYTES : addr_q;
  assign mem_req_data_o     = word_sel_q ? wdata1_q : wdata0_q;
  assign mem_rsp_rdy_o      = (state_q == LSU_WAIT);

  always_comb begin
    state_d    = state_q;
    word_sel_d = word_sel_q;

    unique case (state_q)
      LSU_IDLE: begin
        if (req_fire) begin
          state_d    = LSU_REQ;
          word_sel_d = 1'b0;
        end
      end
      LSU_REQ: begin
        if (mem_req_rdy_i) state_d = LSU_WAIT;  // address held until accepted
      end
      LSU_WAIT: begin
        if (mem_rsp_fire) begin
          if (is_block && !word_sel_q) begin
            state_d    = LSU_REQ;  // second word of the block
            word_sel_d = 1'b1;
          end else begin
            state_d = LSU_RSP;
          end
        end
      end
      LSU_RSP: begin
        if (lsu.rsp_rdy) state_d = LSU_IDLE;
      end
      default: state_d = LSU_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= LSU_IDLE;
      word_sel_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      word_sel_q <= word_sel_d;
    end
  end

  // operation latch and read capture
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      op_q     <= lsu.op;
      addr_q   <= lsu.addr;
      wdata0_q <= lsu.wdata0;
      wdata1_q <= lsu.wdata1;
    end
    if (mem_rsp_fire && !is_store) begin
      if (word_sel_q) rdata1_q <= mem_rsp_data_i;
      else            rdata0_q <= mem_rsp_data_i;
    end
  end

endmodule

// File: falafel_lsu_if.sv
interface falafel_lsu_if;
  import falafel_pkg::*;

  logic    req_val;
  logic    req_rdy;
  lsu_op_t op;
  ptr_t    addr;
  word_t   wdata0;  // size word for block ops
  word_t   wdata1;  // next pointer for block ops

  logic    rsp_val;
  logic    rsp_rdy;
  word_t   rdata0;
  word_t   rdata1;

  modport ctrl (
    output req_val, op, addr, wdata0, wdata1, rsp_rdy,
    input  req_rdy, rsp_val, rdata0, rdata1
  );

  modport lsu (
    input  req_val, op, addr, wdata0, wdata1, rsp_rdy,
    output req_rdy, rsp_val, rdata0, rdata1
  );

endinterface

// File: falafel_pkg.sv
`include "falafel_params.svh"

package falafel_pkg;

  // sizes and memory data
  typedef logic [`FALAFEL_DATA_W-1:0] word_t;

  // byte address
  typedef logic [`FALAFEL_DATA_W-1:0] ptr_t;

  // one of the FALAFEL_OP_* codes
  typedef logic [1:0] lsu_op_t;

endpackage

// File: falafel_params.svh
`ifndef FALAFEL_PARAMS_SVH
`define FALAFEL_PARAMS_SVH

// datapath and address width, one word
`define FALAFEL_DATA_W     32
`define FALAFEL_WORD_BYTES 4

// allocation granularity in bytes
`define FALAFEL_ALIGN      8
// smallest remainder payload worth a new free block
`define FALAFEL_MIN_SPLIT  8

`define FALAFEL_NULL       32'h0000_0000
`define FALAFEL_ERR_NOMEM  32'hffff_ffff

// lsu opcodes
`define FALAFEL_OP_LOAD_WORD   2'd0
`define FALAFEL_OP_STORE_WORD  2'd1
`define FALAFEL_OP_LOAD_BLOCK  2'd2
`define FALAFEL_OP_STORE_BLOCK 2'd3

`endif
